/* hw/flow_settings.svh */
/* Size settings for the flow aggregator.
   FLOW_NUM_FLOWS and FLOW_FIFO_DEPTH must each be at least 2. */
`ifndef FLOW_SETTINGS_SVH
`define FLOW_SETTINGS_SVH

// Number of producer flows merged onto the output bus
`define FLOW_NUM_FLOWS 4

// Width of one data word
`define FLOW_DATA_WIDTH 16

// Entries in each per-flow input FIFO
`define FLOW_FIFO_DEPTH 4

`endif

/* hw/flow_pkg.sv */
/* Shared types of the flow aggregator with sizes from the settings header.
   flow_id_t needs FLOW_NUM_FLOWS of at least 2. */
`include "flow_settings.svh"

package flow_pkg;

  //----------------------------------------------------------
  // Payload and flow types
  //----------------------------------------------------------

  // One data word as carried on every bus
  typedef logic [`FLOW_DATA_WIDTH-1:0] data_t;

  // Index of the flow that each output beat is tagged with
  typedef logic [$clog2(`FLOW_NUM_FLOWS)-1:0] flow_id_t;

  // One bit per flow for valids, readies, requests and grants
  typedef logic [`FLOW_NUM_FLOWS-1:0] flow_vec_t;

endpackage : flow_pkg

/* hw/flow_fifo.sv */
/* Flop-based per-flow input FIFO whose head is read straight from storage.
   A full FIFO refuses a write even when it is popped in the same cycle. */
`include "flow_settings.svh"

module flow_fifo (
  input  logic            clk,
  input  logic            reset,
  input  logic            push_valid,
  input  flow_pkg::data_t push_data,
  output logic            push_ready,
  output logic            pop_valid,
  output flow_pkg::data_t pop_data,
  input  logic            pop_ready
);

  import flow_pkg::*;

  localparam int depth = `FLOW_FIFO_DEPTH;
  localparam int ptr_w = $clog2(depth);
  localparam int cnt_w = $clog2(depth + 1);

  // Storage written at wr_ptr and read at rd_ptr
  data_t            mem [depth];
  logic [ptr_w-1:0] wr_ptr;
  logic [ptr_w-1:0] rd_ptr;
  // Occupancy from 0 to depth
  logic [cnt_w-1:0] count;
  logic             push;
  logic             pop;

  //----------------------------------------------------------
  // Handshake
  //----------------------------------------------------------

  // Full blocks the writer regardless of pop
  assign push_ready = (count != cnt_w'(depth));
  assign pop_valid  = (count != '0);
  assign push       = push_valid && push_ready;
  assign pop        = pop_valid && pop_ready;

  // Head entry stays stable until it is popped
  assign pop_data = mem[rd_ptr];

  //----------------------------------------------------------
  // Storage and pointers
  //----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= push_data;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      // Pointers wrap at depth, which need not be a power of two
      if (push) begin
        wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
      end
      // Push and pop together leave the count alone
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

endmodule : flow_fifo

/* hw/flow_arb_lru.sv */
/* LRU arbiter with an upper-triangle age matrix. Request to grant is
   combinational; the order moves only when enable_priority_update is high. */
`include "flow_settings.svh"

module flow_arb_lru #(
  parameter int num_requesters = `FLOW_NUM_FLOWS
) (
  input  logic                clk,
  input  logic                reset,
  input  flow_pkg::flow_vec_t request,
  input  flow_pkg::flow_vec_t can_grant,
  output flow_pkg::flow_vec_t grant,
  input  logic                enable_priority_update
);

  import flow_pkg::*;

  localparam int num_pairs = num_requesters * (num_requesters - 1) / 2;

  // One bit per pair i<j that is set when i was granted less recently than j
  logic [num_pairs-1:0] age_q;
  logic [num_pairs-1:0] age_d;
  // beaten_by[r][c] is high when c has priority over r
  logic [num_requesters-1:0][num_requesters-1:0] beaten_by;
  // Priority winner before can_grant gating
  flow_vec_t win;

  //----------------------------------------------------------
  // Age matrix decode and next state
  //----------------------------------------------------------

  for (genvar r = 0; r < num_requesters; r++) begin : g_row
    for (genvar c = 0; c < num_requesters; c++) begin : g_col
      if (r < c) begin : g_upper
        // Flat index of pair (r, c)
        localparam int pair = r * num_requesters - (r * (r + 1)) / 2 + c - r - 1;
        // c wins over r when r is not the older one
        assign beaten_by[r][c] = ~age_q[pair];
        // Granted flow becomes most recent against every other flow
        assign age_d[pair] = grant[c] ? 1'b1 :
                             grant[r] ? 1'b0 : age_q[pair];
      end else if (r > c) begin : g_lower
        localparam int pair = c * num_requesters - (c * (c + 1)) / 2 + r - c - 1;
        // Mirror of the upper entry
        assign beaten_by[r][c] = age_q[pair];
      end else begin : g_diag
        assign beaten_by[r][c] = 1'b0;
      end
    end
  end

  //----------------------------------------------------------
  // Grant
  //----------------------------------------------------------

  // Winner is the requester with no older requester present
  for (genvar r = 0; r < num_requesters; r++) begin : g_win
    assign win[r] = request[r] & ~|(request & beaten_by[r]);
  end

  assign grant = win & can_grant;

  //----------------------------------------------------------
  // Priority state
  //----------------------------------------------------------

  // Reset order puts flow 0 highest and the last flow lowest
  always_ff @(posedge clk) begin
    if (reset) begin
      age_q <= '1;
    end else if (enable_priority_update) begin
      age_q <= age_d;
    end
  end

endmodule : flow_arb_lru

/* hw/flow_mux_core.sv */
/* Purely combinational datapath of the flow multiplexer.
   Expects a one-hot grant from the arbiter whenever any flow requests. */
`include "flow_settings.svh"

module flow_mux_core #(
  parameter int num_flows = `FLOW_NUM_FLOWS
) (
  output flow_pkg::flow_vec_t                  request,
  output flow_pkg::flow_vec_t                  can_grant,
  input  flow_pkg::flow_vec_t                  grant,
  output logic                                 enable_priority_update,
  output flow_pkg::flow_vec_t                  push_ready,
  input  flow_pkg::flow_vec_t                  push_valid,
  input  flow_pkg::data_t [num_flows-1:0]      push_data,
  input  logic                                 pop_ready,
  output logic                                 pop_valid,
  output flow_pkg::data_t                      pop_data,
  output flow_pkg::flow_id_t                   pop_flow
);

  import flow_pkg::*;

  //----------------------------------------------------------
  // Arbiter side
  //----------------------------------------------------------

  // Every valid flow competes and none is masked
  assign request   = push_valid;
  assign can_grant = '1;

  // Any request yields a grant, so pop is valid
  assign pop_valid = |request;

  // Age update only on an accepted beat
  assign enable_priority_update = pop_valid && pop_ready;

  // Ready goes back to the granted flow alone
  assign push_ready = grant & {num_flows{pop_ready}};

  //----------------------------------------------------------
  // Data select and flow encode
  //----------------------------------------------------------

  // One-hot AND-OR select with the index encoded from the grant
  always_comb begin
    pop_data = '0;
    pop_flow = '0;
    for (int i = 0; i < num_flows; i++) begin
      pop_data = pop_data | (push_data[i] & {$bits(data_t){grant[i]}});
      if (grant[i]) begin
        pop_flow = pop_flow | flow_id_t'(i);
      end
    end
  end

endmodule : flow_mux_core

/* hw/flow_mux_lru.sv */
/* Zero-latency LRU flow multiplexer. pop_data may change while pop_ready
   is low if a higher-priority flow becomes valid. */
`include "flow_settings.svh"

module flow_mux_lru (
  input  logic                                    clk,
  input  logic                                    reset,
  output flow_pkg::flow_vec_t                     push_ready,
  input  flow_pkg::flow_vec_t                     push_valid,
  input  flow_pkg::data_t [`FLOW_NUM_FLOWS-1:0]   push_data,
  input  logic                                    pop_ready,
  output logic                                    pop_valid,
  output flow_pkg::data_t                         pop_data,
  output flow_pkg::flow_id_t                      pop_flow
);

  import flow_pkg::*;

  // Arbiter to datapath wiring
  flow_vec_t request;
  flow_vec_t can_grant;
  flow_vec_t grant;
  logic      enable_priority_update;

  //----------------------------------------------------------
  // LRU arbiter holding the priority order
  //----------------------------------------------------------

  flow_arb_lru #(
    .num_requesters(`FLOW_NUM_FLOWS)
  ) u_arb (
    .clk,
    .reset,
    .request,
    .can_grant,
    .grant,
    .enable_priority_update
  );

  //----------------------------------------------------------
  // Datapath
  //----------------------------------------------------------

  flow_mux_core #(
    .num_flows(`FLOW_NUM_FLOWS)
  ) u_core (
    .request,
    .can_grant,
    .grant,
    .enable_priority_update,
    .push_ready,
    .push_valid,
    .push_data,
    .pop_ready,
    .pop_valid,
    .pop_data,
    .pop_flow
  );

endmodule : flow_mux_lru

/* hw/flow_aggregator.sv */
/* Flow aggregator top with one input FIFO per flow and an LRU merge onto one bus.
   Minimum latency from an accepted input to out_valid is one cycle. */
`include "flow_settings.svh"

module flow_aggregator (
  input  logic                                    clk,
  input  logic                                    reset,
  input  flow_pkg::flow_vec_t                     in_valid,
  input  flow_pkg::data_t [`FLOW_NUM_FLOWS-1:0]   in_data,
  output flow_pkg::flow_vec_t                     in_ready,
  output logic                                    out_valid,
  output flow_pkg::data_t                         out_data,
  output flow_pkg::flow_id_t                      out_flow,
  input  logic                                    out_ready
);

  import flow_pkg::*;

  // FIFO heads toward the multiplexer
  flow_vec_t                        push_valid;
  flow_vec_t                        push_ready;
  data_t [`FLOW_NUM_FLOWS-1:0]      push_data;

  //----------------------------------------------------------
  // Per-flow input buffering
  //----------------------------------------------------------

  for (genvar i = 0; i < `FLOW_NUM_FLOWS; i++) begin : g_flow
    // in_ready drops once this flow's FIFO is full
    flow_fifo u_fifo (
      .clk,
      .reset,
      .push_valid (in_valid[i]),
      .push_data  (in_data[i]),
      .push_ready (in_ready[i]),
      .pop_valid  (push_valid[i]),
      .pop_data   (push_data[i]),
      .pop_ready  (push_ready[i])
    );
  end

  //----------------------------------------------------------
  // Merge onto the output bus
  //----------------------------------------------------------

  // Heads only move on a pop, so out_valid holds under back-pressure
  flow_mux_lru u_mux (
    .clk,
    .reset,
    .push_ready,
    .push_valid,
    .push_data,
    .pop_ready  (out_ready),
    .pop_valid  (out_valid),
    .pop_data   (out_data),
    .pop_flow   (out_flow)
  );

endmodule : flow_aggregator

/* sim/tb_flow_aggregator.sv */
/* Checks flow_aggregator against a queue-per-flow model with an LRU order list.
   Random valids take two xorshift bits per flow, so at most 15 flows. */
`include "flow_settings.svh"

module tb_flow_aggregator;

  import flow_pkg::*;

  localparam int num_flows   = `FLOW_NUM_FLOWS;
  localparam int depth       = `FLOW_FIFO_DEPTH;
  localparam int id_w        = $bits(flow_id_t);
  localparam int seq_w       = `FLOW_DATA_WIDTH - id_w;
  localparam int drain_limit = 200;

  // DUT ports
  logic                  clk = 1'b0;
  logic                  reset = 1'b1;
  flow_vec_t             in_valid = '0;
  data_t [num_flows-1:0] in_data = '0;
  flow_vec_t             in_ready;
  logic                  out_valid;
  data_t                 out_data;
  flow_id_t              out_flow;
  logic                  out_ready = 1'b0;

  // Reference model with one queue per flow plus LRU order (oldest first)
  data_t            exp_q [num_flows][$];
  int               lru_order [num_flows];
  logic [seq_w-1:0] seq [num_flows];
  logic             exp_valid = 1'b0;
  flow_id_t         exp_flow = '0;
  data_t            exp_data = '0;
  flow_vec_t        exp_ready = '1;
  // Expected flow during the round-robin phase
  flow_id_t         rr_next = '0;
  logic             rr_check = 1'b0;

  // Handshakes seen at the last rising edge
  flow_vec_t in_acc;
  logic      out_acc;
  logic      reset_seen = 1'b0;

  // Stimulus modes are 0 idle, 1 always and 2 random
  int          valid_mode = 0;
  int          ready_mode = 0;
  logic [31:0] rng = 32'd57932;
  string       test_name = "reset";
  int          error_count = 0;
  int          errors_before = 0;
  int          test_count = 0;
  int          failed_tests = 0;

  always #50 clk = ~clk;

  flow_aggregator DUT (
    .clk,
    .reset,
    .in_valid,
    .in_data,
    .in_ready,
    .out_valid,
    .out_data,
    .out_flow,
    .out_ready
  );

  always @(posedge clk) begin
    reset_seen <= reset;
    if (reset) begin
      in_acc  <= '0;
      out_acc <= 1'b0;
    end else begin
      in_acc  <= in_valid & in_ready;
      out_acc <= out_valid && out_ready;
    end
  end

  //----------------------------------------------------------
  // Checks
  //----------------------------------------------------------

  function automatic void log_mismatch(string what, logic [31:0] expected, logic [31:0] actual);
    error_count++;
    $display("error %s: %s expected 0x%0h actual 0x%0h", test_name, what, expected, actual);
  endfunction

  // Reset state checks skip the first edge where the FIFOs are still unknown
  a_reset_valid: assert property (@(posedge clk) (reset && reset_seen) |-> !out_valid)
    else log_mismatch("out_valid in reset", 32'd0, 32'($sampled(out_valid)));
  a_reset_ready: assert property (@(posedge clk) (reset && reset_seen) |-> in_ready == '1)
    else log_mismatch("in_ready in reset", 32'(flow_vec_t'('1)), 32'($sampled(in_ready)));

  a_valid: assert property (@(posedge clk) disable iff (reset) out_valid == exp_valid)
    else log_mismatch("out_valid", 32'(exp_valid), 32'($sampled(out_valid)));
  // Winner must be the oldest flow with words queued
  a_flow: assert property (@(posedge clk) disable iff (reset)
                           (out_valid && exp_valid) |-> out_flow == exp_flow)
    else log_mismatch("out_flow", 32'(exp_flow), 32'($sampled(out_flow)));
  a_data: assert property (@(posedge clk) disable iff (reset)
                           (out_valid && exp_valid) |-> out_data == exp_data)
    else log_mismatch("out_data", 32'(exp_data), 32'($sampled(out_data)));
  a_tag: assert property (@(posedge clk) disable iff (reset)
                          out_valid |-> out_data[`FLOW_DATA_WIDTH-1 -: id_w] == out_flow)
    else log_mismatch("out_data flow tag", 32'($sampled(out_flow)),
                      32'($sampled(out_data) >> seq_w));
  // in_ready low exactly when the FIFO holds depth words
  a_ready: assert property (@(posedge clk) disable iff (reset) in_ready == exp_ready)
    else log_mismatch("in_ready", 32'(exp_ready), 32'($sampled(in_ready)));
  a_hold: assert property (@(posedge clk) disable iff (reset)
                           (out_valid && !out_ready) |=> out_valid)
    else log_mismatch("out_valid under back-pressure", 32'd1, 32'($sampled(out_valid)));
  a_rotate: assert property (@(posedge clk) disable iff (reset)
                             (rr_check && out_valid && out_ready) |-> out_flow == rr_next)
    else log_mismatch("rotation out_flow", 32'(rr_next), 32'($sampled(out_flow)));

  //----------------------------------------------------------
  // Model and stimulus
  //----------------------------------------------------------

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic int queued_words();
    int n;
    n = 0;
    for (int f = 0; f < num_flows; f++)
      n += exp_q[f].size();
    return n;
  endfunction

  task automatic update_model();
    int pos;
    for (int f = 0; f < num_flows; f++) begin
      if (in_acc[f]) begin
        exp_q[f].push_back(in_data[f]);
        seq[f] = seq[f] + 1'b1;
      end
    end
    // Accepted beat leaves the queue the model expected to win
    if (out_acc && exp_valid) begin
      void'(exp_q[exp_flow].pop_front());
      // Granted flow moves to most recent
      pos = 0;
      for (int i = 0; i < num_flows; i++)
        if (lru_order[i] == int'(exp_flow))
          pos = i;
      for (int i = pos; i < num_flows - 1; i++)
        lru_order[i] = lru_order[i + 1];
      lru_order[num_flows - 1] = int'(exp_flow);
      // Full flows are served in index order
      rr_next = flow_id_t'((int'(rr_next) + 1) % num_flows);
    end
  endtask

  task automatic compute_expected();
    exp_valid = 1'b0;
    exp_flow  = '0;
    exp_data  = '0;
    for (int i = 0; i < num_flows; i++) begin
      if (!exp_valid && exp_q[lru_order[i]].size() > 0) begin
        exp_valid = 1'b1;
        exp_flow  = flow_id_t'(lru_order[i]);
        exp_data  = exp_q[lru_order[i]][0];
      end
    end
    for (int f = 0; f < num_flows; f++)
      exp_ready[f] = exp_q[f].size() < depth;
  endtask

  task automatic drive_inputs();
    rng = xorshift32(rng);
    for (int f = 0; f < num_flows; f++) begin
      if (valid_mode != 2)
        in_valid[f] = (valid_mode == 1);
      else if (!(in_valid[f] && !in_acc[f]))
        // A pending word stays offered until taken
        in_valid[f] = rng[2*f +: 2] != 2'b00;
      in_data[f] = {flow_id_t'(f), seq[f]};
    end
    out_ready = (ready_mode == 1) || (ready_mode == 2 && rng[31]);
  endtask

  task automatic step_cycle();
    @(negedge clk);
    update_model();
    compute_expected();
    drive_inputs();
  endtask

  task automatic run_cycles(input int n);
    repeat (n) step_cycle();
  endtask

  task automatic finish_test();
    test_count++;
    if (error_count == errors_before) begin
      $display("test %s: ok", test_name);
    end else begin
      failed_tests++;
      $display("test %s: %0d errors", test_name, error_count - errors_before);
    end
    errors_before = error_count;
  endtask

  //----------------------------------------------------------
  // Test sequence
  //----------------------------------------------------------

  initial begin
    int waited;
    for (int f = 0; f < num_flows; f++) begin
      lru_order[f] = f;
      seq[f]       = '0;
    end
    // Release after three reset edges on a falling edge
    repeat (3) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;
    run_cycles(2);
    finish_test();

    // Fill every FIFO with the output stalled
    test_name  = "back_pressure";
    valid_mode = 1;
    ready_mode = 0;
    run_cycles(depth + 4);
    finish_test();

    // All flows full with the output always ready
    test_name  = "lru_rotation";
    rr_check   = 1'b1;
    ready_mode = 1;
    run_cycles(num_flows * 4);
    rr_check = 1'b0;
    finish_test();

    test_name  = "random_traffic";
    valid_mode = 2;
    ready_mode = 2;
    run_cycles(400);
    finish_test();

    test_name  = "drain";
    valid_mode = 0;
    ready_mode = 1;
    waited     = 0;
    step_cycle();
    while (queued_words() != 0 && waited < drain_limit) begin
      step_cycle();
      waited++;
    end
    if (queued_words() != 0) begin
      error_count++;
      $display("drain timed out with %0d words never reaching the output", queued_words());
    end
    // Output must stay idle once empty
    run_cycles(8);
    finish_test();

    $display("tests %0d, tests with errors %0d, errors %0d", test_count, failed_tests,
             error_count);
    if (error_count == 0)
      $display("Regression passed");
    else
      $display("Regression failed");
    $finish;
  end

endmodule : tb_flow_aggregator

/* compile.f */
+incdir+hw
hw/flow_pkg.sv
hw/flow_fifo.sv
hw/flow_arb_lru.sv
hw/flow_mux_core.sv
hw/flow_mux_lru.sv
hw/flow_aggregator.sv
sim/tb_flow_aggregator.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_flow_aggregator
FILELIST  ?= compile.f
PASS_MSG  := Regression passed

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf obj_dir
